//--- Bender.yml
package:
  name: rename

sources:
  - src/rename_pkg.sv
  - src/map_table.sv
  - src/free_list.sv
  - src/rename_stage.sv
  - src/rob_fifo.sv
  - src/retire_stage.sv
  - src/rename_top.sv
  - target: simulation
    files:
      - tb/rename_tb.sv

//--- compile.f
src/rename_pkg.sv
src/map_table.sv
src/free_list.sv
src/rename_stage.sv
src/rob_fifo.sv
src/retire_stage.sv
src/rename_top.sv
tb/rename_tb.sv

//--- src/free_list.sv
`timescale 1ns/1ns
`default_nettype none

module free_list (
	input wire clk,
	input wire reset,
	input wire flush,
	input wire alloc,
	input wire commit,
	input wire rename_pkg::preg_idx_t retire_preg,
	input wire rename_pkg::preg_idx_t freed_preg,
	output rename_pkg::preg_idx_t free_preg,
	output logic free_avail
);
	import rename_pkg::*;

	// upper half free, lower half holds the identity mappings
	localparam free_vec_t reset_vec = {{(num_preg - num_arch){1'b1}}, {num_arch{1'b0}}};

	free_vec_t spec_q;
	free_vec_t spec_d;
	free_vec_t ret_q;
	free_vec_t ret_d;

	// lowest set bit wins, scan from the top down
	always_comb begin
		free_preg = '0;
		for (int i = num_preg - 1; i >= 0; i--) begin
			if (spec_q[i]) begin
				free_preg = preg_idx_t'(i);
			end
		end
	end

	assign free_avail = |spec_q;

	always_comb begin
		spec_d = spec_q;
		ret_d = ret_q;
		if (flush) begin
			spec_d = ret_q; // back to the retired view
		end else begin
			if (alloc) begin
				spec_d[free_preg] = 1'b0;
			end
			if (commit) begin
				spec_d[freed_preg] = 1'b1; // old mapping is dead now
				ret_d[retire_preg] = 1'b0;
				ret_d[freed_preg] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			spec_q <= reset_vec;
			ret_q <= reset_vec;
		end else begin
			spec_q <= spec_d;
			ret_q <= ret_d;
		end
	end

endmodule

`default_nettype wire

//--- src/map_table.sv
`timescale 1ns/1ns
`default_nettype none

module map_table (
	input wire clk,
	input wire reset,
	input wire copy,
	input wire rename_pkg::map_image_t image_in,
	output rename_pkg::map_image_t image_out,
	input wire rename_pkg::arch_idx_t rd_a_idx,
	output rename_pkg::preg_idx_t rd_a,
	input wire rename_pkg::arch_idx_t rd_b_idx,
	output rename_pkg::preg_idx_t rd_b,
	input wire wr_en,
	input wire rename_pkg::arch_idx_t wr_idx,
	input wire rename_pkg::preg_idx_t wr_data
);
	import rename_pkg::*;

	map_image_t map_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < num_arch; i++) begin
				map_q[i] <= preg_idx_t'(i); // arch n -> preg n
			end
		end else if (copy) begin
			map_q <= image_in; // bulk load beats the write port
		end else if (wr_en) begin
			map_q[wr_idx] <= wr_data;
		end
	end

	// reads see the state before this cycle's write
	assign rd_a = map_q[rd_a_idx];
	assign rd_b = map_q[rd_b_idx];

	assign image_out = map_q;

endmodule

`default_nettype wire

//--- src/rename_pkg.sv
`default_nettype none

package rename_pkg;

	localparam int num_arch = 32;
	localparam int num_preg = 64;

	localparam int arch_w = $clog2(num_arch);
	localparam int preg_w = $clog2(num_preg);

	typedef logic [arch_w-1:0] arch_idx_t; // architectural register index
	typedef logic [preg_w-1:0] preg_idx_t; // physical register index

	// one whole alias table, entry n holds the mapping of arch reg n
	typedef preg_idx_t [num_arch-1:0] map_image_t;

	typedef logic [num_preg-1:0] free_vec_t; // 1 = free

	// in-flight destination, oldest at the buffer head
	typedef struct packed {
		arch_idx_t arch_dest;
		preg_idx_t preg_dest;
	} rename_entry_t;

endpackage

`default_nettype wire

//--- src/rename_stage.sv
`timescale 1ns/1ns
`default_nettype none

module rename_stage (
	input wire clk,
	input wire reset,
	input wire flush,
	input wire issue,
	input wire rename_pkg::arch_idx_t src_a,
	input wire rename_pkg::arch_idx_t src_b,
	input wire rename_pkg::arch_idx_t dest,
	output rename_pkg::preg_idx_t preg_a,
	output rename_pkg::preg_idx_t preg_b,
	output rename_pkg::preg_idx_t preg_dest,
	output logic issue_ready,
	input wire buf_full,
	output logic push,
	output rename_pkg::rename_entry_t push_entry,
	input wire rename_pkg::map_image_t rrat_image,
	input wire commit,
	input wire rename_pkg::preg_idx_t retire_preg,
	input wire rename_pkg::preg_idx_t freed_preg
);

	logic free_avail;

	assign issue_ready = free_avail && !buf_full;
	assign push = issue && issue_ready && !flush; // flush drops the issue

	assign push_entry = '{arch_dest: dest, preg_dest: preg_dest};

	map_table u_spec_table (
		.clk      (clk),
		.reset    (reset),
		.copy     (flush), // restore from retirement table
		.image_in (rrat_image),
		.image_out(),
		.rd_a_idx (src_a),
		.rd_a     (preg_a),
		.rd_b_idx (src_b),
		.rd_b     (preg_b),
		.wr_en    (push),
		.wr_idx   (dest),
		.wr_data  (preg_dest)
	);

	free_list u_free_list (
		.clk        (clk),
		.reset      (reset),
		.flush      (flush),
		.alloc      (push),
		.commit     (commit),
		.retire_preg(retire_preg),
		.freed_preg (freed_preg),
		.free_preg  (preg_dest), // lowest free preg becomes the new dest
		.free_avail (free_avail)
	);

endmodule

`default_nettype wire

//--- src/rename_top.sv
`timescale 1ns/1ns
`default_nettype none

module rename_top #(
	parameter int rob_depth = 8
) (
	input wire clk,
	input wire reset,
	input wire issue,
	input wire rename_pkg::arch_idx_t src_a,
	input wire rename_pkg::arch_idx_t src_b,
	input wire rename_pkg::arch_idx_t dest,
	input wire commit,
	input wire flush,
	output rename_pkg::preg_idx_t preg_a,
	output rename_pkg::preg_idx_t preg_b,
	output rename_pkg::preg_idx_t preg_dest,
	output logic issue_ready,
	output logic commit_valid,
	output rename_pkg::preg_idx_t retire_preg,
	output rename_pkg::preg_idx_t freed_preg
);
	import rename_pkg::*;

	rename_entry_t push_entry;
	rename_entry_t head;
	map_image_t rrat_image;
	logic buf_full;
	logic push;
	logic not_empty;
	logic take;

	rename_stage u_rename_stage (
		.clk        (clk),
		.reset      (reset),
		.flush      (flush),
		.issue      (issue),
		.src_a      (src_a),
		.src_b      (src_b),
		.dest       (dest),
		.preg_a     (preg_a),
		.preg_b     (preg_b),
		.preg_dest  (preg_dest),
		.issue_ready(issue_ready),
		.buf_full   (buf_full),
		.push       (push),
		.push_entry (push_entry),
		.rrat_image (rrat_image),
		.commit     (take),
		.retire_preg(retire_preg),
		.freed_preg (freed_preg)
	);

	rob_fifo #(
		.rob_depth(rob_depth)
	) u_rob_fifo (
		.clk       (clk),
		.reset     (reset),
		.flush     (flush),
		.push      (push),
		.push_entry(push_entry),
		.pop       (take),
		.head      (head),
		.full      (buf_full),
		.not_empty (not_empty)
	);

	retire_stage u_retire_stage (
		.clk         (clk),
		.reset       (reset),
		.flush       (flush),
		.commit      (commit),
		.head        (head),
		.not_empty   (not_empty),
		.commit_valid(commit_valid),
		.take        (take),
		.retire_preg (retire_preg),
		.freed_preg  (freed_preg),
		.rrat_image  (rrat_image)
	);

endmodule

`default_nettype wire

//--- src/retire_stage.sv
`timescale 1ns/1ns
`default_nettype none

module retire_stage (
	input wire clk,
	input wire reset,
	input wire flush,
	input wire commit,
	input wire rename_pkg::rename_entry_t head,
	input wire not_empty,
	output logic commit_valid,
	output logic take,
	output rename_pkg::preg_idx_t retire_preg,
	output rename_pkg::preg_idx_t freed_preg,
	output rename_pkg::map_image_t rrat_image
);

	assign commit_valid = not_empty;
	assign take = commit && not_empty && !flush; // no retire in a flush cycle
	assign retire_preg = head.preg_dest;

	// retirement table never bulk loads
	map_table u_ret_table (
		.clk      (clk),
		.reset    (reset),
		.copy     (1'b0),
		.image_in ('0),
		.image_out(rrat_image),
		.rd_a_idx (head.arch_dest),
		.rd_a     (freed_preg), // mapping about to be overwritten
		.rd_b_idx ('0),
		.rd_b     (),
		.wr_en    (take),
		.wr_idx   (head.arch_dest),
		.wr_data  (head.preg_dest)
	);

endmodule

`default_nettype wire

//--- src/rob_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module rob_fifo #(
	parameter int rob_depth = 8
) (
	input wire clk,
	input wire reset,
	input wire flush,
	input wire push,
	input wire rename_pkg::rename_entry_t push_entry,
	input wire pop,
	output rename_pkg::rename_entry_t head,
	output logic full,
	output logic not_empty
);
	import rename_pkg::*;

	localparam int ptr_w = (rob_depth > 1) ? $clog2(rob_depth) : 1;
	localparam int cnt_w = $clog2(rob_depth + 1);

	typedef logic [ptr_w-1:0] ptr_t;
	typedef logic [cnt_w-1:0] cnt_t;

	rename_entry_t entries [rob_depth];
	ptr_t rd_ptr;
	ptr_t wr_ptr;
	cnt_t count;
	logic do_push;
	logic do_pop;

	// wrap explicitly, depth need not be a power of two
	function automatic ptr_t next_ptr(ptr_t p);
		return (p == ptr_t'(rob_depth - 1)) ? '0 : p + ptr_t'(1);
	endfunction

	assign full = (count == cnt_t'(rob_depth));
	assign not_empty = (count != '0);
	assign do_push = push && !full;
	assign do_pop = pop && not_empty;
	assign head = entries[rd_ptr]; // oldest entry

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0; // everything in flight is squashed
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + cnt_t'(do_push) - cnt_t'(do_pop);
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			entries[wr_ptr] <= push_entry;
		end
	end

endmodule

`default_nettype wire

//--- tb/rename_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rename_tb;
	import rename_pkg::*;

	localparam int rob_depth = 8;
	localparam int max_cycles = 2000; // ~60 directed + 400 random cycles, with margin

	logic clk = 1'b0;
	logic reset;
	logic issue;
	arch_idx_t src_a;
	arch_idx_t src_b;
	arch_idx_t dest;
	logic commit;
	logic flush;
	preg_idx_t preg_a;
	preg_idx_t preg_b;
	preg_idx_t preg_dest;
	preg_idx_t retire_preg;
	preg_idx_t freed_preg;
	logic issue_ready;
	logic commit_valid;

	// reference model
	preg_idx_t spec_map [num_arch];
	preg_idx_t ret_map [num_arch];
	free_vec_t spec_free;
	free_vec_t ret_free;
	rename_entry_t rob_q [$];
	int cycles = 0;
	integer seed;

	rename_top #(.rob_depth(rob_depth)) u_rename_top (
		.clk(clk), .reset(reset), .issue(issue), .src_a(src_a), .src_b(src_b),
		.dest(dest), .commit(commit), .flush(flush), .preg_a(preg_a), .preg_b(preg_b),
		.preg_dest(preg_dest), .issue_ready(issue_ready), .commit_valid(commit_valid),
		.retire_preg(retire_preg), .freed_preg(freed_preg)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("run did not finish within %0d cycles", max_cycles);
			$display("TEST FAIL");
			$fatal(1, "timeout");
		end
	end

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			$display("TEST FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// scan upward, first set bit is the lowest free register
	function automatic preg_idx_t lowest_free(input free_vec_t v);
		preg_idx_t r;
		logic found;
		r = '0;
		found = 1'b0;
		for (int i = 0; i < num_preg; i++) begin
			if (v[i] && !found) begin
				r = preg_idx_t'(i);
				found = 1'b1;
			end
		end
		return r;
	endfunction

	task automatic reset_dut();
		{issue, commit, flush} = 3'b000;
		{src_a, src_b, dest} = '0;
		reset = 1'b1;
		for (int i = 0; i < num_arch; i++) begin
			spec_map[i] = preg_idx_t'(i);
			ret_map[i] = preg_idx_t'(i);
		end
		spec_free = {{(num_preg - num_arch){1'b1}}, {num_arch{1'b0}}};
		ret_free = spec_free;
		rob_q.delete();
		repeat (10) @(posedge clk);
		#10 reset = 1'b0;
	endtask

	// one cycle: drive, compare with the model, then step the model at the edge
	task automatic run_cycle(input logic iss, input arch_idx_t a, input arch_idx_t b,
			input arch_idx_t d, input logic com, input logic fl);
		preg_idx_t exp_dest;
		preg_idx_t old_map;
		logic exp_ready;
		logic exp_valid;
		rename_entry_t e;
		issue = iss;
		src_a = a;
		src_b = b;
		dest = d;
		commit = com;
		flush = fl;
		#10;
		exp_dest = lowest_free(spec_free);
		exp_ready = (spec_free != '0) && (rob_q.size() < rob_depth);
		exp_valid = (rob_q.size() != 0);
		check("issue_ready", issue_ready, exp_ready);
		check("commit_valid", commit_valid, exp_valid);
		check("preg_a", preg_a, spec_map[a]);
		check("preg_b", preg_b, spec_map[b]);
		if (spec_free != '0) check("preg_dest", preg_dest, exp_dest);
		if (exp_valid) begin
			check("retire_preg", retire_preg, rob_q[0].preg_dest);
			check("freed_preg", freed_preg, ret_map[rob_q[0].arch_dest]);
		end
		if (fl) begin
			for (int i = 0; i < num_arch; i++) spec_map[i] = ret_map[i];
			spec_free = ret_free;
			rob_q.delete(); // squash everything in flight
		end else begin
			if (com && exp_valid) begin
				e = rob_q.pop_front();
				old_map = ret_map[e.arch_dest];
				ret_map[e.arch_dest] = e.preg_dest;
				ret_free[e.preg_dest] = 1'b0;
				ret_free[old_map] = 1'b1;
				spec_free[old_map] = 1'b1;
			end
			if (iss && exp_ready) begin
				spec_map[d] = exp_dest;
				spec_free[exp_dest] = 1'b0;
				e.arch_dest = d;
				e.preg_dest = exp_dest;
				rob_q.push_back(e);
			end
		end
		@(posedge clk);
		#10;
	endtask

	task automatic test_first_issue();
		check("commit_valid", commit_valid, 1'b0);
		check("issue_ready", issue_ready, 1'b1);
		check("preg_dest", preg_dest, 32);
		run_cycle(1'b1, 5'd5, 5'd7, 5'd5, 1'b0, 1'b0); // source reads old r5 mapping
		check("preg_a", preg_a, 32); // src_a still r5
		run_cycle(1'b1, 5'd5, 5'd0, 5'd6, 1'b0, 1'b0);
	endtask

	task automatic test_alloc_order();
		for (int i = 0; i < 4; i++) begin
			check("preg_dest", preg_dest, 34 + i);
			run_cycle(1'b1, arch_idx_t'(7 + i), 5'd5, arch_idx_t'(8 + i), 1'b0, 1'b0);
		end
	endtask

	task automatic test_commit_order();
		run_cycle(1'b0, 5'd0, 5'd0, 5'd0, 1'b1, 1'b0); // retires r5, frees preg 5
		check("preg_dest", preg_dest, 5);
		run_cycle(1'b1, 5'd5, 5'd6, 5'd9, 1'b1, 1'b0);
		repeat (2) run_cycle(1'b0, 5'd9, 5'd8, 5'd0, 1'b1, 1'b0);
	endtask

	task automatic test_full_buffer();
		preg_idx_t next_dest;
		preg_idx_t r3_map;
		while (rob_q.size() < rob_depth) run_cycle(1'b1, 5'd3, 5'd9, 5'd12, 1'b0, 1'b0);
		check("issue_ready", issue_ready, 1'b0);
		next_dest = lowest_free(spec_free);
		r3_map = spec_map[3];
		run_cycle(1'b1, 5'd3, 5'd2, 5'd3, 1'b0, 1'b0); // dropped, buffer full
		check("preg_dest", preg_dest, next_dest);
		check("preg_a", preg_a, r3_map); // src_a still r3
		run_cycle(1'b0, 5'd3, 5'd12, 5'd0, 1'b1, 1'b0);
		check("issue_ready", issue_ready, 1'b1);
	endtask

	task automatic test_flush();
		run_cycle(1'b1, 5'd12, 5'd9, 5'd10, 1'b1, 1'b0);
		run_cycle(1'b1, 5'd10, 5'd12, 5'd11, 1'b0, 1'b0);
		run_cycle(1'b1, 5'd1, 5'd2, 5'd4, 1'b1, 1'b1); // issue and commit dropped
		check("commit_valid", commit_valid, 1'b0);
		check("preg_dest", preg_dest, lowest_free(ret_free));
		run_cycle(1'b1, 5'd10, 5'd11, 5'd12, 1'b0, 1'b0);
	endtask

	task automatic test_random();
		logic iss;
		logic com;
		logic fl;
		for (int i = 0; i < 400; i++) begin
			iss = $random(seed) & 1;
			com = $random(seed) & 1;
			fl = (($random(seed) & 31) == 0); // rare flush
			run_cycle(iss, arch_idx_t'($random(seed)), arch_idx_t'($random(seed)),
				arch_idx_t'($random(seed)), com, fl);
		end
	endtask

	initial begin
		seed = 84575;
		reset_dut();
		test_first_issue();
		test_alloc_order();
		test_commit_order();
		test_full_buffer();
		test_flush();
		test_random();
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire
